// File: rv_pkg.sv
//====================================================================
// Shared definitions for the single-cycle RV32I core.
// Holds the data path widths, the memory depth, the opcode and
// control encodings, the decoded control record and the commit
// record. Every unit refers to these by rv_pkg:: scoped names.
//====================================================================
package rv_pkg;

	localparam int xlen = 32; // data path width.

	typedef logic [xlen-1:0] word_t;
	typedef logic [31:0]     inst_t;
	typedef logic [4:0]      reg_idx_t;

	localparam word_t pc_reset   = '0;
	localparam int    dmem_words = 256; // data memory depth in words.

	// Major opcodes of the supported RV32I subset.
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and
	} alu_op_e;

	typedef enum logic [1:0] {src_a_rs1, src_a_pc, src_a_zero} src_a_e;
	typedef enum logic [1:0] {src_b_rs2, src_b_imm, src_b_four} src_b_e;
	typedef enum logic {wb_alu, wb_mem} wb_src_e;

	// Everything the decoder hands to the rest of the core.
	typedef struct packed {
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		reg_idx_t   rd;
		word_t      imm;
		logic [2:0] funct3;
		alu_op_e    alu_op;
		src_a_e     src_a;
		src_b_e     src_b;
		wb_src_e    wb_src;
		logic       rd_w_en;
		logic       mem_r_en;
		logic       mem_w_en;
		logic       is_branch;
		logic       is_jal;
		logic       is_jalr;
		logic       illegal;
	} ctrl_t;

	// One record per executed instruction.
	typedef struct packed {
		word_t    pc;
		word_t    dnpc;
		logic     rd_w_en;
		reg_idx_t rd;
		word_t    x_rd;
	} commit_t;

endpackage

// File: rv_idu.sv
//====================================================================
// Instruction decoder. Splits the instruction into register indices,
// builds the sign-extended immediate for its format and generates the
// operand selects, the ALU operation and the enables. Purely
// combinational; unknown opcodes raise illegal with all enables low.
//====================================================================
`timescale 1ns/1ps

module rv_idu (
	input  rv_pkg::inst_t inst,
	output rv_pkg::ctrl_t ctrl
);

	rv_pkg::opcode_e opcode;
	rv_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;

	// funct3 picks the operation, inst[30] selects sub and sra.
	function automatic rv_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
		rv_pkg::alu_op_e op;
		case (f3)
			3'b000:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001:  op = rv_pkg::alu_sll;
			3'b010:  op = rv_pkg::alu_slt;
			3'b011:  op = rv_pkg::alu_sltu;
			3'b100:  op = rv_pkg::alu_xor;
			3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110:  op = rv_pkg::alu_or;
			default: op = rv_pkg::alu_and;
		endcase
		return op;
	endfunction

	assign opcode = rv_pkg::opcode_e'(inst[6:0]);

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		ctrl        = '0;
		ctrl.rs1    = inst[19:15];
		ctrl.rs2    = inst[24:20];
		ctrl.rd     = inst[11:7];
		ctrl.funct3 = inst[14:12];
		ctrl.alu_op = rv_pkg::alu_add; // address and link sums all use add.
		ctrl.src_a  = rv_pkg::src_a_rs1;
		ctrl.src_b  = rv_pkg::src_b_imm;
		ctrl.wb_src = rv_pkg::wb_alu;
		case (opcode)
			rv_pkg::op_lui: begin
				ctrl.imm     = imm_u;
				ctrl.src_a   = rv_pkg::src_a_zero;
				ctrl.rd_w_en = 1'b1;
			end
			rv_pkg::op_auipc: begin
				ctrl.imm     = imm_u;
				ctrl.src_a   = rv_pkg::src_a_pc;
				ctrl.rd_w_en = 1'b1;
			end
			rv_pkg::op_jal: begin
				ctrl.imm     = imm_j;
				ctrl.src_a   = rv_pkg::src_a_pc; // the alu forms the link value.
				ctrl.src_b   = rv_pkg::src_b_four;
				ctrl.is_jal  = 1'b1;
				ctrl.rd_w_en = 1'b1;
			end
			rv_pkg::op_jalr: begin
				ctrl.imm     = imm_i; // the alu forms rs1 + imm as the target.
				ctrl.is_jalr = 1'b1;
				ctrl.rd_w_en = 1'b1;
			end
			rv_pkg::op_branch: begin
				ctrl.imm       = imm_b;
				ctrl.src_b     = rv_pkg::src_b_rs2;
				ctrl.is_branch = 1'b1;
			end
			rv_pkg::op_load: begin
				ctrl.imm = imm_i;
				if (inst[14:12] == 3'b010) begin
					ctrl.mem_r_en = 1'b1;
					ctrl.rd_w_en  = 1'b1;
					ctrl.wb_src   = rv_pkg::wb_mem;
				end else begin
					ctrl.illegal = 1'b1; // only word loads exist here.
				end
			end
			rv_pkg::op_store: begin
				ctrl.imm = imm_s;
				if (inst[14:12] == 3'b010)
					ctrl.mem_w_en = 1'b1;
				else
					ctrl.illegal = 1'b1;
			end
			rv_pkg::op_imm: begin
				ctrl.imm     = imm_i;
				// inst[30] is only an alt bit for the immediate shifts.
				ctrl.alu_op  = alu_from_funct(inst[14:12], inst[30] && inst[14:12] == 3'b101);
				ctrl.rd_w_en = 1'b1;
			end
			rv_pkg::op_reg: begin
				ctrl.src_b   = rv_pkg::src_b_rs2;
				ctrl.alu_op  = alu_from_funct(inst[14:12], inst[30]);
				ctrl.rd_w_en = 1'b1;
			end
			default: ctrl.illegal = 1'b1;
		endcase
	end

	// load and store come from different opcodes, so one instruction
	// may never ask the data memory for both.
	always_comb begin
		if (!$isunknown(inst)) begin
			a_mem_excl: assert (!(ctrl.mem_r_en && ctrl.mem_w_en))
				else $error("decoder set mem_r_en and mem_w_en for inst %h", inst);
		end
	end

endmodule

// File: rv_gpr.sv
//====================================================================
// General register file with two combinational read ports and one
// write port on the rising clock edge. x0 has no storage: it always
// reads zero and writes to it are dropped.
//====================================================================
`timescale 1ns/1ps

module rv_gpr (
	input                   clk,
	input                   arst_n,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	input  rv_pkg::reg_idx_t rd,
	input                   rd_w_en,
	input  rv_pkg::word_t    x_rd,
	output rv_pkg::word_t    x_rs1,
	output rv_pkg::word_t    x_rs2
);

	rv_pkg::word_t regs [1:31]; // x1..x31.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (rd_w_en && rd != 5'd0) begin
			regs[rd] <= x_rd;
		end
	end

	assign x_rs1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign x_rs2 = (rs2 == 5'd0) ? '0 : regs[rs2];

	a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
		rs1 == 5'd0 |-> x_rs1 == '0)
		else $error("x0 read back a nonzero value.");

endmodule

// File: rv_exu.sv
//====================================================================
// Execution unit. Selects operand a from rs1, the pc or zero and
// operand b from rs2, the immediate or four, then applies the ALU
// operation. The single result serves as the write-back value, the
// load/store address and the JALR target.
//====================================================================
`timescale 1ns/1ps

module rv_exu (
	input  rv_pkg::ctrl_t ctrl,
	input  rv_pkg::word_t pc,
	input  rv_pkg::word_t x_rs1,
	input  rv_pkg::word_t x_rs2,
	output rv_pkg::word_t alu_result
);

	rv_pkg::word_t opd_a, opd_b;
	logic [4:0]    shamt;

	always_comb begin
		case (ctrl.src_a)
			rv_pkg::src_a_rs1: opd_a = x_rs1;
			rv_pkg::src_a_pc:  opd_a = pc;
			default:           opd_a = '0; // lui adds the immediate to zero.
		endcase
		case (ctrl.src_b)
			rv_pkg::src_b_rs2: opd_b = x_rs2;
			rv_pkg::src_b_imm: opd_b = ctrl.imm;
			default:           opd_b = 32'd4;
		endcase
	end

	assign shamt = opd_b[4:0];

	always_comb begin
		case (ctrl.alu_op)
			rv_pkg::alu_add:  alu_result = opd_a + opd_b;
			rv_pkg::alu_sub:  alu_result = opd_a - opd_b;
			rv_pkg::alu_sll:  alu_result = opd_a << shamt;
			rv_pkg::alu_slt:  alu_result = {31'b0, $signed(opd_a) < $signed(opd_b)};
			rv_pkg::alu_sltu: alu_result = {31'b0, opd_a < opd_b};
			rv_pkg::alu_xor:  alu_result = opd_a ^ opd_b;
			rv_pkg::alu_srl:  alu_result = opd_a >> shamt;
			rv_pkg::alu_sra:  alu_result = rv_pkg::word_t'($signed(opd_a) >>> shamt);
			rv_pkg::alu_or:   alu_result = opd_a | opd_b;
			default:          alu_result = opd_a & opd_b;
		endcase
	end

endmodule

// File: rv_bcu.sv
//====================================================================
// Branch compare unit. Decides whether a conditional branch is taken
// from funct3 and the two register operands, using its own equality,
// signed and unsigned compares beside the ALU.
//====================================================================
`timescale 1ns/1ps

module rv_bcu (
	input                is_branch,
	input        [2:0]   funct3,
	input rv_pkg::word_t x_rs1,
	input rv_pkg::word_t x_rs2,
	output logic         taken
);

	logic eq, lt, ltu;

	assign eq  = (x_rs1 == x_rs2);
	assign lt  = ($signed(x_rs1) < $signed(x_rs2));
	assign ltu = (x_rs1 < x_rs2);

	always_comb begin
		taken = 1'b0;
		if (is_branch) begin
			case (funct3)
				3'b000:  taken = eq;   // beq.
				3'b001:  taken = !eq;  // bne.
				3'b100:  taken = lt;   // blt.
				3'b101:  taken = !lt;  // bge.
				3'b110:  taken = ltu;  // bltu.
				3'b111:  taken = !ltu; // bgeu.
				default: taken = 1'b0;
			endcase
		end
	end

	// the decoder passes branches through unchecked, so funct3 2 and 3
	// would reach this unit as a silent not-taken.
	always_comb begin
		if (!$isunknown({is_branch, funct3})) begin
			a_funct3_ok: assert (!(is_branch && funct3[2:1] == 2'b01))
				else $error("branch with reserved funct3 %0d.", funct3);
		end
	end

endmodule

// File: rv_pcu.sv
//====================================================================
// Program counter unit. Holds the pc and forms the next pc: JALR
// takes the ALU result with bit zero cleared, JAL and taken branches
// take pc plus the immediate, and all else falls through to pc + 4.
// The pc only advances on edges where pc_en is high.
//====================================================================
`timescale 1ns/1ps

module rv_pcu (
	input                 clk,
	input                 arst_n,
	input                 pc_en,
	input  rv_pkg::ctrl_t ctrl,
	input                 taken,
	input  rv_pkg::word_t alu_result,
	output rv_pkg::word_t pc,
	output rv_pkg::word_t dnpc
);

	rv_pkg::word_t pc_seq, pc_rel;

	assign pc_seq = pc + 32'd4;
	assign pc_rel = pc + ctrl.imm;

	always_comb begin
		if (ctrl.is_jalr)
			dnpc = {alu_result[31:1], 1'b0};
		else if (ctrl.is_jal || (ctrl.is_branch && taken))
			dnpc = pc_rel;
		else
			dnpc = pc_seq;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc <= rv_pkg::pc_reset;
		else if (pc_en)
			pc <= dnpc; // held while the core is stalled.
	end

	// jump and branch targets come from the decoder and the alu, so a
	// bad offset shows up here as a misaligned pc.
	a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		pc[1:0] == 2'b00)
		else $error("pc %h is not word aligned.", pc);

endmodule

// File: rv_lsu.sv
//====================================================================
// Data memory of dmem_words 32-bit words. Reads are combinational
// and return zero when no load is active; writes land on the rising
// edge. The word index is taken from the address bits above bit one,
// so addresses wrap modulo the depth.
//====================================================================
`timescale 1ns/1ps

module rv_lsu (
	input                 clk,
	input                 mem_r_en,
	input                 mem_w_en,
	input  rv_pkg::word_t addr,
	input  rv_pkg::word_t w_data,
	output rv_pkg::word_t r_data
);

	rv_pkg::word_t mem [rv_pkg::dmem_words];
	logic [$clog2(rv_pkg::dmem_words)-1:0] idx;

	assign idx = addr[$clog2(rv_pkg::dmem_words)+1:2];

	always_ff @(posedge clk) begin
		if (mem_w_en)
			mem[idx] <= w_data;
	end

	// a store in this cycle is not visible until the next one.
	assign r_data = mem_r_en ? mem[idx] : '0;

	// only word accesses exist, so the ALU address must be aligned.
	a_addr_aligned: assert property (@(posedge clk)
		(mem_r_en || mem_w_en) |-> addr[1:0] == 2'b00)
		else $error("misaligned data access at %h.", addr);

endmodule

// File: rv_core.sv
//====================================================================
// Top of the single-cycle RV32I core. Exposes pc to an outside
// instruction memory and takes inst back in the same cycle. Wires
// decode, register file, ALU, branch compare, pc unit and data
// memory, and reports every executed instruction on commit.
// pc_en low holds the pc, the registers and the memory.
//====================================================================
`timescale 1ns/1ps

module rv_core (
	input                   clk,
	input                   arst_n,
	input                   pc_en,
	output rv_pkg::word_t   pc,
	input  rv_pkg::inst_t   inst,
	output rv_pkg::commit_t commit
);

	rv_pkg::ctrl_t ctrl;
	rv_pkg::word_t x_rs1, x_rs2, x_rd;
	rv_pkg::word_t alu_result, dnpc, mem_r_data, link;
	logic          taken, rd_w_en, mem_w_en;

	assign rd_w_en  = ctrl.rd_w_en && pc_en;
	assign mem_w_en = ctrl.mem_w_en && pc_en;

	rv_idu u_idu (.inst(inst), .ctrl(ctrl));

	rv_gpr u_gpr (
		.clk(clk), .arst_n(arst_n),
		.rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd(ctrl.rd),
		.rd_w_en(rd_w_en), .x_rd(x_rd),
		.x_rs1(x_rs1), .x_rs2(x_rs2)
	);

	rv_exu u_exu (
		.ctrl(ctrl), .pc(pc), .x_rs1(x_rs1), .x_rs2(x_rs2),
		.alu_result(alu_result)
	);

	rv_bcu u_bcu (
		.is_branch(ctrl.is_branch), .funct3(ctrl.funct3),
		.x_rs1(x_rs1), .x_rs2(x_rs2), .taken(taken)
	);

	rv_pcu u_pcu (
		.clk(clk), .arst_n(arst_n), .pc_en(pc_en),
		.ctrl(ctrl), .taken(taken), .alu_result(alu_result),
		.pc(pc), .dnpc(dnpc)
	);

	rv_lsu u_lsu (
		.clk(clk), .mem_r_en(ctrl.mem_r_en), .mem_w_en(mem_w_en),
		.addr(alu_result), .w_data(x_rs2), .r_data(mem_r_data)
	);

	// jalr spends the alu on its target, so its link value needs its own adder.
	assign link = pc + 32'd4;

	always_comb begin
		case (ctrl.wb_src)
			rv_pkg::wb_mem: x_rd = mem_r_data;
			default:        x_rd = ctrl.is_jalr ? link : alu_result;
		endcase
	end

	always_comb begin
		commit.pc      = pc;
		commit.dnpc    = dnpc;
		commit.rd_w_en = rd_w_en; // low while stalled.
		commit.rd      = ctrl.rd;
		commit.x_rd    = x_rd;
	end

endmodule

// File: tb_rv_core.sv
//====================================================================
// Testbench for the single-cycle core. Loads the program and the
// expected commit values from rv_core_tests.txt, serves instructions
// from pc, checks each commit and inserts one three-cycle stall.
//====================================================================
`timescale 1ns/1ps

module tb_rv_core;

	logic clk, arst_n, pc_en;
	rv_pkg::word_t   pc;
	rv_pkg::inst_t   inst;
	rv_pkg::commit_t commit;

	string       names [64];
	logic [31:0] imem [64];
	logic        exp_wen [64];
	logic [4:0]  exp_rd [64];
	logic [31:0] exp_x [64];
	logic [31:0] exp_dnpc [64];
	int          n_lines = 0;
	int          cycle_limit = 1000;
	int          cycles = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	logic [31:0] stall_pc = 32'hffff_fffc;

	rv_core u_dut (
		.clk(clk), .arst_n(arst_n), .pc_en(pc_en),
		.pc(pc), .inst(inst), .commit(commit)
	);

	// the instruction memory returns a nop outside the program.
	assign inst = (int'(pc >> 2) < n_lines) ? imem[pc >> 2] : 32'h0000_0013;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout, the program never reached its end marker");
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic load_program(output bit ok);
		int fd;
		string line, nm;
		logic [31:0] w, wen, rd, x, d;
		fd = $fopen("rv_core_tests.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while ($fgets(line, fd) > 0) begin
				if (line.getc(0) != "#" &&
					$sscanf(line, "%s %h %h %h %h %h", nm, w, wen, rd, x, d) == 6) begin
					names[n_lines]    = nm;
					imem[n_lines]     = w;
					exp_wen[n_lines]  = wen[0];
					exp_rd[n_lines]   = rd[4:0];
					exp_x[n_lines]    = x;
					exp_dnpc[n_lines] = d;
					if (nm == "lw_stall")
						stall_pc = 32'(n_lines * 4);
					n_lines++;
				end
			end
			$fclose(fd);
			cycle_limit = 4 * n_lines + 20; // every line runs once, plus reset and stall.
		end
	endtask

	task automatic check_line(input int idx, input logic [31:0] exp_pc);
		int errs;
		errs = 0;
		if (names[idx] == "skip") begin
			$display("line %0d at %h should have been skipped but was executed", idx, pc);
			tests_failed++;
		end else begin
			assert (commit.pc == exp_pc) else begin
				$display("error %s pc expected %h actual %h",
					names[idx], exp_pc, commit.pc);
				errs++;
			end
			assert (commit.rd_w_en == exp_wen[idx]) else begin
				$display("error %s rd_w_en expected %0d actual %0d",
					names[idx], exp_wen[idx], commit.rd_w_en);
				errs++;
			end
			if (exp_wen[idx]) begin
				assert (commit.rd == exp_rd[idx]) else begin
					$display("error %s rd expected %0d actual %0d",
						names[idx], exp_rd[idx], commit.rd);
					errs++;
				end
				assert (commit.x_rd == exp_x[idx]) else begin
					$display("error %s x_rd expected %h actual %h",
						names[idx], exp_x[idx], commit.x_rd);
					errs++;
				end
			end
			assert (commit.dnpc == exp_dnpc[idx]) else begin
				$display("error %s dnpc expected %h actual %h",
					names[idx], exp_dnpc[idx], commit.dnpc);
				errs++;
			end
			if (errs == 0) begin
				tests_passed++;
				$display("test %s passed", names[idx]);
			end else begin
				tests_failed++;
				$display("test %s failed", names[idx]);
			end
		end
	endtask

	task automatic run_program();
		int idx, stall_left, stall_errs;
		bit arm, stall_done;
		logic [31:0] exp_pc;
		stall_left = 0;
		stall_errs = 0;
		arm = 0;
		stall_done = 0;
		exp_pc = rv_pkg::pc_reset;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		pc_en  <= 1'b1;
		forever begin
			@(negedge clk);
			idx = int'(pc >> 2);
			if (idx >= n_lines) begin
				$display("pc %h ran past the end of the program", pc);
				tests_failed++;
				break;
			end
			if (names[idx] == "end")
				break;
			if (pc_en) begin
				check_line(idx, exp_pc);
				exp_pc = exp_dnpc[idx]; // the next commit must come from here.
				if (!stall_done && exp_pc == stall_pc)
					arm = 1;
			end else begin
				// while stalled the pc holds and nothing is written.
				assert (pc == stall_pc && !commit.rd_w_en) else begin
					$display("error stall pc expected %h actual %h, rd_w_en %0d",
						stall_pc, pc, commit.rd_w_en);
					stall_errs++;
				end
			end
			@(posedge clk);
			if (arm) begin
				pc_en <= 1'b0;
				stall_left = 3;
				arm = 0;
				stall_done = 1;
			end else if (stall_left > 0) begin
				stall_left--;
				if (stall_left == 0) begin
					pc_en <= 1'b1;
					if (stall_errs == 0) begin
						tests_passed++;
						$display("test stall passed");
					end else begin
						tests_failed++;
						$display("test stall failed");
					end
				end
			end
		end
	endtask

	initial begin
		bit ok;
		arst_n = 1'b0;
		pc_en  = 1'b0;
		load_program(ok);
		if (!ok) begin
			$display("could not open rv_core_tests.txt");
			$display("*** FAILED ***");
			$finish;
		end else begin
			run_program();
			$display("tests passed %0d failed %0d", tests_passed, tests_failed);
			if (tests_failed == 0)
				$display("*** PASSED ***");
			else
				$display("*** FAILED ***");
			$finish;
		end
	end

endmodule

// File: rv_core.f
rv_pkg.sv
rv_idu.sv
rv_gpr.sv
rv_exu.sv
rv_bcu.sv
rv_pcu.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_rv_core
FILELIST  = rv_core.f
BIN       = obj_dir/V$(TOP)
PASS      = \*\*\* PASSED \*\*\*

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: rv_core_tests.txt
# columns: name inst rd_w_en rd x_rd dnpc, all in hex
# line n of the program sits at address 4n; skip lines must never execute
addi_pos   00500093 1 01 00000005 00000004
addi_neg   ff800113 1 02 fffffff8 00000008
add        002081b3 1 03 fffffffd 0000000c
sub        40208233 1 04 0000000d 00000010
sra_neg    401152b3 1 05 ffffffff 00000014
srl_neg    00115333 1 06 07ffffff 00000018
slt        001123b3 1 07 00000001 0000001c
sltu       00113433 1 08 00000000 00000020
slli       00409493 1 09 00000050 00000024
srai       40215513 1 0a fffffffe 00000028
xori       0ff0c593 1 0b 000000fa 0000002c
or         0090e633 1 0c 00000055 00000030
andi       07f17693 1 0d 00000078 00000034
write_x0   00708013 1 00 0000000c 00000038
read_x0    00100733 1 0e 00000005 0000003c
lui        123457b7 1 0f 12345000 00000040
auipc      00001817 1 10 00001040 00000044
jal        008008ef 1 11 00000048 0000004c
skip       00100093 1 01 00000001 0000004c
jalr       00988967 1 12 00000050 00000050
beq_t      00e08463 0 00 00000000 00000058
skip       00100093 1 01 00000001 00000058
bne_n      00e09463 0 00 00000000 0000005c
blt_t      00114463 0 00 00000000 00000064
skip       00100093 1 01 00000001 00000064
bge_n      00115463 0 00 00000000 00000068
bltu_n     00116463 0 00 00000000 0000006c
bgeu_t     00117463 0 00 00000000 00000074
skip       00100093 1 01 00000001 00000074
beq_n      00208463 0 00 00000000 00000078
bne_t      00209463 0 00 00000000 00000080
skip       00100093 1 01 00000001 00000080
blt_n      0020c463 0 00 00000000 00000084
bge_t      0020d463 0 00 00000000 0000008c
skip       00100093 1 01 00000001 0000008c
bltu_t     0020e463 0 00 00000000 00000094
skip       00100093 1 01 00000001 00000094
bgeu_n     0020f463 0 00 00000000 00000098
sw_a       04f02023 0 00 00000000 0000009c
sw_b       05002223 0 00 00000000 000000a0
lw_a       04002983 1 13 12345000 000000a4
lw_b       04402a03 1 14 00001040 000000a8
sw_over    04102023 0 00 00000000 000000ac
lw_stall   04402a83 1 15 00001040 000000b0
lw_over    04002b03 1 16 00000005 000000b4
end        00000013 0 00 00000000 00000000
